// File: vfb.f
vfb_timing_pkg.sv
vfb_pixel_pkg.sv
vga_timing_gen.sv
luma_packer.sv
frame_buffer_arbiter.sv
scan_out.sv
vfb_top.sv
tb_vfb_clock.sv
tb_vfb_checker.sv
tb_vfb.sv

// File: tb_vfb.sv
`timescale 1ns/1ps

module tb_vfb;
   import vfb_timing_pkg::*;
   import vfb_pixel_pkg::*;

   localparam int H_ACTIVE     = DEF_H_ACTIVE;
   localparam int H_SYNC_START = DEF_H_SYNC_START;
   localparam int H_SYNC_END   = DEF_H_SYNC_END;
   localparam int H_TOTAL      = DEF_H_TOTAL;
   localparam int V_ACTIVE     = DEF_V_ACTIVE;
   localparam int V_SYNC_START = DEF_V_SYNC_START;
   localparam int V_SYNC_END   = DEF_V_SYNC_END;
   localparam int V_TOTAL      = DEF_V_TOTAL;

   localparam int          CLK_PERIOD_NS = 8;
   localparam int          RESET_CYCLES  = 3;
   localparam int          NUM_TESTS     = 4;
   localparam int          FRAME_PIX     = H_ACTIVE * V_ACTIVE;
   localparam int          FRAME_CYCLES  = H_TOTAL * V_TOTAL;
   // ten frames for every test
   localparam int          WATCHDOG_NS   =
      CLK_PERIOD_NS * (RESET_CYCLES + NUM_TESTS * FRAME_CYCLES * 10);
   localparam logic [31:0] SEED          = 32'h23300ba7;

   logic        clk;
   logic        rst_n;
   logic        pix_valid;
   logic        pix_sof;
   luma_t       pix_luma;
   logic        pix_ready;
   logic        clear;
   logic        test_bars;
   logic        clear_busy;
   luma_t       vga_pixel;
   logic        vga_hsync;
   logic        vga_vsync;
   logic        vga_blank;
   logic [2:0]  test_id;
   logic [31:0] rand_state;
   int          sent     = 0;
   int          timeouts = 0;

   tb_vfb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
      .clk   (clk),
      .rst_n (rst_n)
   );

   vfb_top #(
      .H_ACTIVE (H_ACTIVE), .H_SYNC_START (H_SYNC_START),
      .H_SYNC_END (H_SYNC_END), .H_TOTAL (H_TOTAL),
      .V_ACTIVE (V_ACTIVE), .V_SYNC_START (V_SYNC_START),
      .V_SYNC_END (V_SYNC_END), .V_TOTAL (V_TOTAL)
   ) uut (
      .clk (clk), .rst_n (rst_n),
      .pix_valid (pix_valid), .pix_sof (pix_sof), .pix_luma (pix_luma),
      .pix_ready (pix_ready), .clear (clear), .test_bars (test_bars),
      .clear_busy (clear_busy), .vga_pixel (vga_pixel),
      .vga_hsync (vga_hsync), .vga_vsync (vga_vsync), .vga_blank (vga_blank)
   );

   tb_vfb_checker #(
      .H_ACTIVE (H_ACTIVE), .H_SYNC_START (H_SYNC_START),
      .H_SYNC_END (H_SYNC_END), .H_TOTAL (H_TOTAL),
      .V_ACTIVE (V_ACTIVE), .V_SYNC_START (V_SYNC_START),
      .V_SYNC_END (V_SYNC_END), .V_TOTAL (V_TOTAL)
   ) u_checker (
      .clk (clk), .rst_n (rst_n), .test_id (test_id),
      .pix_valid (pix_valid), .pix_sof (pix_sof), .pix_luma (pix_luma),
      .pix_ready (pix_ready), .clear (clear), .test_bars (test_bars),
      .clear_busy (clear_busy), .vga_pixel (vga_pixel),
      .vga_hsync (vga_hsync), .vga_vsync (vga_vsync), .vga_blank (vga_blank)
   );

   //////////////////////////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic next_random(output logic [31:0] r);
      rand_state = xorshift32(rand_state);
      r          = rand_state;
   endtask

   // every wait ends 1 ns after a rising edge
   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // hold the sample until the edge that takes it
   task automatic send_pixel(input logic sof, input luma_t luma);
      logic taken;
      pix_valid = 1'b1;
      pix_sof   = sof;
      pix_luma  = luma;
      taken     = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = pix_ready;
         idle_cycles(1);
      end
      pix_valid = 1'b0;
      pix_sof   = 1'b0;
      sent++;
   endtask

   task automatic send_frame(input logic with_gaps);
      logic [31:0] r;
      luma_t       luma;
      for (int n = 0; n < FRAME_PIX; n++) begin
         next_random(r);
         luma = r[7:0];
         // values right at the threshold
         if (n % 37 == 5) begin
            luma = 8'd127;
         end else if (n % 37 == 6) begin
            luma = 8'd128;
         end
         send_pixel(n == 0, luma);
         if (with_gaps && r[9:8] == 2'b00) begin
            idle_cycles(int'(r[11:10]) + 1);
         end
      end
   endtask

   // one sample waits out the whole clear, sof alone never completes a word
   task automatic run_clear();
      clear = 1'b1;
      idle_cycles(1);
      clear = 1'b0;
      wait (clear_busy === 1'b1);
      idle_cycles(1);
      send_pixel(1'b1, 8'hff);
   endtask

   task automatic wait_checked_frames(input int count);
      int target;
      target = u_checker.full_frames + count;
      wait (u_checker.full_frames >= target);
      idle_cycles(1);
   endtask

   task automatic finish_run();
      int total;
      total = u_checker.timing_errors + u_checker.pixel_errors +
              u_checker.protocol_errors + timeouts;
      $display("errors: timing %0d, pixel %0d, protocol %0d, timeout %0d",
               u_checker.timing_errors, u_checker.pixel_errors,
               u_checker.protocol_errors, timeouts);
      if (total == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   endtask

   //////////////////////////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      pix_valid  = 1'b0;
      pix_sof    = 1'b0;
      pix_luma   = '0;
      clear      = 1'b0;
      test_bars  = 1'b0;
      test_id    = 3'd0;
      rand_state = SEED;
      wait (rst_n === 1'b1);
      idle_cycles(1);
      // random frame with gaps, then a frame of pure bursts
      test_id = 3'd1;
      send_frame(1'b1);
      wait_checked_frames(1);
      test_id = 3'd2;
      send_frame(1'b0);
      wait_checked_frames(1);
      // first counted frame may have started before the switch
      test_id   = 3'd3;
      test_bars = 1'b1;
      wait_checked_frames(2);
      test_bars = 1'b0;
      test_id   = 3'd4;
      run_clear();
      wait_checked_frames(1);
      u_checker.compare_sample_count(sent);
      finish_run();
   end

   initial begin
      #(WATCHDOG_NS);
      timeouts++;
      $display("watchdog expired after %0d ns before the test sequence ended", WATCHDOG_NS);
      finish_run();
   end

endmodule

// File: tb_vfb_checker.sv
`timescale 1ns/1ps

module tb_vfb_checker #(
   parameter int H_ACTIVE     = vfb_timing_pkg::DEF_H_ACTIVE,
   parameter int H_SYNC_START = vfb_timing_pkg::DEF_H_SYNC_START,
   parameter int H_SYNC_END   = vfb_timing_pkg::DEF_H_SYNC_END,
   parameter int H_TOTAL      = vfb_timing_pkg::DEF_H_TOTAL,
   parameter int V_ACTIVE     = vfb_timing_pkg::DEF_V_ACTIVE,
   parameter int V_SYNC_START = vfb_timing_pkg::DEF_V_SYNC_START,
   parameter int V_SYNC_END   = vfb_timing_pkg::DEF_V_SYNC_END,
   parameter int V_TOTAL      = vfb_timing_pkg::DEF_V_TOTAL
) (
   input logic                 clk,
   input logic                 rst_n,
   input logic [2:0]           test_id,
   input logic                 pix_valid,
   input logic                 pix_sof,
   input vfb_pixel_pkg::luma_t pix_luma,
   input logic                 pix_ready,
   input logic                 clear,
   input logic                 test_bars,
   input logic                 clear_busy,
   input vfb_pixel_pkg::luma_t vga_pixel,
   input logic                 vga_hsync,
   input logic                 vga_vsync,
   input logic                 vga_blank
);
   import vfb_pixel_pkg::*;

   localparam int FRAME_PIX   = H_ACTIVE * V_ACTIVE;
   localparam int FRAME_WORDS = FRAME_PIX / PIX_PER_WORD;

   // display model, one entry per pixel
   luma_t model [FRAME_PIX];
   logic  known [FRAME_PIX];
   luma_t pend [PIX_PER_WORD];
   int    cur_lane = 0;
   int    cur_word = 0;

   // raster position of the pixel now on the outputs
   int   h;
   int   v;
   logic locked;
   logic prev_vsync;
   logic prev_busy;
   logic bars_prev;
   // busy_seen collects input or clear activity between two vsync falls
   logic busy_seen;
   logic pix_enable;
   logic frame_ok;

   int timing_errors   = 0;
   int pixel_errors    = 0;
   int protocol_errors = 0;
   int accepted        = 0;
   int full_frames     = 0;

   initial begin
      for (int i = 0; i < FRAME_PIX; i++) begin
         known[i] = 1'b0;
      end
   end

   function automatic string test_label(input logic [2:0] id);
      case (id)
         3'd1:    return "threshold";
         3'd2:    return "burst";
         3'd3:    return "test_bars";
         3'd4:    return "clear";
         default: return "startup";
      endcase
   endfunction

   // black or white by the luma threshold
   function automatic luma_t binarize(input luma_t luma);
      return (luma > LUMA_THRESHOLD) ? 8'd255 : 8'd0;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // memory model
   //////////////////////////////////////////////////////////////////////

   // pixel n lands in word n/4, lane n mod 4, a word counts once complete
   task automatic store_sample(input logic sof, input luma_t luma);
      if (sof) begin
         cur_lane = 0;
         cur_word = 0;
      end
      pend[cur_lane] = binarize(luma);
      if (cur_lane == PIX_PER_WORD - 1) begin
         for (int k = 0; k < PIX_PER_WORD; k++) begin
            model[cur_word * PIX_PER_WORD + k] = pend[k];
            known[cur_word * PIX_PER_WORD + k] = 1'b1;
         end
         cur_lane = 0;
         cur_word = (cur_word + 1) % FRAME_WORDS;
      end else begin
         cur_lane++;
      end
   endtask

   task automatic wipe_model();
      for (int i = 0; i < FRAME_PIX; i++) begin
         model[i] = 8'd0;
         known[i] = 1'b1;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // comparisons
   //////////////////////////////////////////////////////////////////////

   task automatic report_value(input string what, input logic [7:0] exp_val,
                               input logic [7:0] act_val);
      $display("ERROR %s: %s at (%0d,%0d) expected %0h actual %0h",
               test_label(test_id), what, h, v, exp_val, act_val);
   endtask

   task automatic check_sync(input string what, input logic exp_val, input logic act_val);
      if (act_val !== exp_val) begin
         timing_errors++;
         report_value(what, 8'(exp_val), 8'(act_val));
      end
   endtask

   task automatic check_pixel(input luma_t exp_val);
      if (vga_pixel !== exp_val) begin
         pixel_errors++;
         report_value("pixel", exp_val, vga_pixel);
      end
   endtask

   task automatic check_raster();
      logic exp_blank;
      int   idx;
      if (!locked && prev_vsync && !vga_vsync) begin
         // first vsync fall belongs to line V_SYNC_START, pixel 0
         locked = 1'b1;
         h      = 0;
         v      = V_SYNC_START;
      end
      prev_vsync = vga_vsync;
      if (locked) begin
         if (h == 0 && v == V_SYNC_START) begin
            pix_enable = !busy_seen;
            busy_seen  = 1'b0;
         end
         if (h == 0 && v == 0) begin
            frame_ok = pix_enable;
         end
         exp_blank = (h >= H_ACTIVE) || (v >= V_ACTIVE);
         check_sync("hsync", !(h >= H_SYNC_START && h < H_SYNC_END), vga_hsync);
         check_sync("vsync", !(v >= V_SYNC_START && v < V_SYNC_END), vga_vsync);
         check_sync("blank", exp_blank, vga_blank);
         idx = v * H_ACTIVE + h;
         if (exp_blank) begin
            check_pixel(8'd0);
         end else if (bars_prev) begin
            // 3-bit ramp from hcount bits 4 to 2
            check_pixel(luma_t'(((h / 4) % 8) * 32));
         end else if (pix_enable && known[idx]) begin
            check_pixel(model[idx]);
         end else begin
            frame_ok = 1'b0;
         end
         if (h == H_ACTIVE - 1 && v == V_ACTIVE - 1 && frame_ok) begin
            full_frames++;
         end
         h++;
         if (h == H_TOTAL) begin
            h = 0;
            v = (v + 1) % V_TOTAL;
         end
      end
      bars_prev = test_bars;
   endtask

   // transfers seen here happen on the next rising edge
   task automatic track_samples();
      if (clear_busy && pix_ready) begin
         protocol_errors++;
         $display("%s: pix_ready is high while the clear is still running",
                  test_label(test_id));
      end
      if (prev_busy && !clear_busy) begin
         wipe_model();
      end
      if (pix_valid && pix_ready) begin
         accepted++;
         store_sample(pix_sof, pix_luma);
      end
      if ((pix_valid && pix_ready) || clear || clear_busy) begin
         busy_seen  = 1'b1;
         pix_enable = 1'b0;
         frame_ok   = 1'b0;
      end
      prev_busy = clear_busy;
   endtask

   task automatic compare_sample_count(input int sent);
      if (sent != accepted) begin
         protocol_errors++;
         $display("ERROR %s: accepted samples expected %0d actual %0d",
                  test_label(test_id), sent, accepted);
      end
   endtask

   // outputs settle half a cycle before the next edge
   always @(negedge clk) begin
      if (!rst_n) begin
         locked     = 1'b0;
         prev_vsync = 1'b1;
         prev_busy  = 1'b0;
         bars_prev  = 1'b0;
         busy_seen  = 1'b0;
         pix_enable = 1'b0;
         frame_ok   = 1'b0;
      end else begin
         check_raster();
         track_samples();
      end
   end

endmodule

// File: tb_vfb_clock.sv
`timescale 1ns/1ps

module tb_vfb_clock #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic rst_n
);

   // free running clock
   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;
   end

   // reset drops 1 ns after a rising edge, same as the other inputs
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

// File: vfb_top.sv
`timescale 1ns/1ps

module vfb_top #(
   parameter int H_ACTIVE     = vfb_timing_pkg::DEF_H_ACTIVE,
   parameter int H_SYNC_START = vfb_timing_pkg::DEF_H_SYNC_START,
   parameter int H_SYNC_END   = vfb_timing_pkg::DEF_H_SYNC_END,
   parameter int H_TOTAL      = vfb_timing_pkg::DEF_H_TOTAL,
   parameter int V_ACTIVE     = vfb_timing_pkg::DEF_V_ACTIVE,
   parameter int V_SYNC_START = vfb_timing_pkg::DEF_V_SYNC_START,
   parameter int V_SYNC_END   = vfb_timing_pkg::DEF_V_SYNC_END,
   parameter int V_TOTAL      = vfb_timing_pkg::DEF_V_TOTAL
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 pix_valid,
   input  logic                 pix_sof,
   input  vfb_pixel_pkg::luma_t pix_luma,
   output logic                 pix_ready,
   input  logic                 clear,
   input  logic                 test_bars,
   output logic                 clear_busy,
   output vfb_pixel_pkg::luma_t vga_pixel,
   output logic                 vga_hsync,
   output logic                 vga_vsync,
   output logic                 vga_blank
);
   import vfb_timing_pkg::*;
   import vfb_pixel_pkg::*;

   // raster
   hcount_t  hcount;
   vcount_t  vcount;
   logic     hsync_raw;
   logic     vsync_raw;
   logic     blank_raw;

   // packer write port
   logic     wr_valid;
   logic     wr_ready;
   fb_addr_t wr_addr;
   fb_word_t wr_word;

   // display read data
   fb_word_t rd_word;

   //////////////////////////////////////////////////////////////////////
   // timing, packing, memory and scan-out
   //////////////////////////////////////////////////////////////////////

   vga_timing_gen #(
      .H_ACTIVE     (H_ACTIVE),
      .H_SYNC_START (H_SYNC_START),
      .H_SYNC_END   (H_SYNC_END),
      .H_TOTAL      (H_TOTAL),
      .V_ACTIVE     (V_ACTIVE),
      .V_SYNC_START (V_SYNC_START),
      .V_SYNC_END   (V_SYNC_END),
      .V_TOTAL      (V_TOTAL)
   ) u_timing (
      .clk       (clk),
      .rst_n     (rst_n),
      .hcount    (hcount),
      .vcount    (vcount),
      .hsync_raw (hsync_raw),
      .vsync_raw (vsync_raw),
      .blank_raw (blank_raw)
   );

   luma_packer #(
      .H_ACTIVE (H_ACTIVE),
      .V_ACTIVE (V_ACTIVE)
   ) u_packer (
      .clk        (clk),
      .rst_n      (rst_n),
      .pix_valid  (pix_valid),
      .pix_sof    (pix_sof),
      .pix_luma   (pix_luma),
      .pix_ready  (pix_ready),
      .clear_busy (clear_busy),
      .wr_valid   (wr_valid),
      .wr_addr    (wr_addr),
      .wr_word    (wr_word),
      .wr_ready   (wr_ready)
   );

   frame_buffer_arbiter #(
      .H_ACTIVE (H_ACTIVE),
      .V_ACTIVE (V_ACTIVE)
   ) u_arbiter (
      .clk        (clk),
      .rst_n      (rst_n),
      .hcount     (hcount),
      .vcount     (vcount),
      .blank_raw  (blank_raw),
      .wr_valid   (wr_valid),
      .wr_addr    (wr_addr),
      .wr_word    (wr_word),
      .wr_ready   (wr_ready),
      .clear      (clear),
      .clear_busy (clear_busy),
      .rd_word    (rd_word)
   );

   scan_out u_scan (
      .clk       (clk),
      .rst_n     (rst_n),
      .hcount    (hcount),
      .hsync_raw (hsync_raw),
      .vsync_raw (vsync_raw),
      .blank_raw (blank_raw),
      .rd_word   (rd_word),
      .test_bars (test_bars),
      .vga_pixel (vga_pixel),
      .vga_hsync (vga_hsync),
      .vga_vsync (vga_vsync),
      .vga_blank (vga_blank)
   );

endmodule

// File: scan_out.sv
`timescale 1ns/1ps

module scan_out (
   input  logic                    clk,
   input  logic                    rst_n,
   input  vfb_timing_pkg::hcount_t hcount,
   input  logic                    hsync_raw,
   input  logic                    vsync_raw,
   input  logic                    blank_raw,
   input  vfb_pixel_pkg::fb_word_t rd_word,
   input  logic                    test_bars,
   output vfb_pixel_pkg::luma_t    vga_pixel,
   output logic                    vga_hsync,
   output logic                    vga_vsync,
   output logic                    vga_blank
);
   import vfb_pixel_pkg::*;

   // {hsync, vsync, blank} while idle
   localparam logic [2:0] SYNC_IDLE = 3'b111;

   logic [4:0] hc_d1;
   logic [4:0] hc_d2;
   logic [2:0] sync_d1;
   logic [2:0] sync_d2;
   fb_word_t   word_hold;
   lane_t      lane;
   luma_t      lane_pix;
   luma_t      bar_pix;
   luma_t      next_pix;

   //////////////////////////////////////////////////////////////////////
   // sync pipeline, three stages to line up with the pixel
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sync_d1                            <= SYNC_IDLE;
         sync_d2                            <= SYNC_IDLE;
         {vga_hsync, vga_vsync, vga_blank} <= SYNC_IDLE;
      end else begin
         sync_d1                            <= {hsync_raw, vsync_raw, blank_raw};
         sync_d2                            <= sync_d1;
         {vga_hsync, vga_vsync, vga_blank} <= sync_d2;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // pixel path
   //////////////////////////////////////////////////////////////////////

   assign lane     = lane_t'(hc_d2);
   assign lane_pix = word_hold[lane*LUMA_W +: LUMA_W];

   // bars step every 4 pixels
   assign bar_pix = {hc_d2[4:2], 5'b0};

   // blanked pixels are always black
   assign next_pix = sync_d2[0] ? LUMA_BLACK :
                     test_bars  ? bar_pix    : lane_pix;

   always_ff @(posedge clk) begin
      hc_d1 <= hcount[4:0];
      hc_d2 <= hc_d1;
      // rd_word is valid one cycle after a group start
      if (lane_t'(hc_d1) == '0) begin
         word_hold <= rd_word;
      end
      vga_pixel <= next_pix;
   end

endmodule

// File: frame_buffer_arbiter.sv
`timescale 1ns/1ps

module frame_buffer_arbiter #(
   parameter int H_ACTIVE = vfb_timing_pkg::DEF_H_ACTIVE,
   parameter int V_ACTIVE = vfb_timing_pkg::DEF_V_ACTIVE
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  vfb_timing_pkg::hcount_t hcount,
   input  vfb_timing_pkg::vcount_t vcount,
   input  logic                    blank_raw,
   input  logic                    wr_valid,
   input  vfb_pixel_pkg::fb_addr_t wr_addr,
   input  vfb_pixel_pkg::fb_word_t wr_word,
   output logic                    wr_ready,
   input  logic                    clear,
   output logic                    clear_busy,
   output vfb_pixel_pkg::fb_word_t rd_word
);
   import vfb_pixel_pkg::*;

   localparam int       FRAME_WORDS = H_ACTIVE * V_ACTIVE / PIX_PER_WORD;
   localparam int       ADDR_W      = $clog2(FRAME_WORDS);
   localparam fb_addr_t LAST_ADDR   = fb_addr_t'(FRAME_WORDS - 1);

   // slot positions inside each 4-pixel group
   localparam lane_t RD_PHASE = lane_t'(0);
   localparam lane_t WR_PHASE = lane_t'(2);

   fb_word_t     mem [FRAME_WORDS];
   clear_state_t clr_state;
   fb_addr_t     clr_addr;
   fb_addr_t     rd_addr;
   lane_t        phase;
   logic         rd_slot;
   logic         wr_slot;
   logic         clr_write;
   logic         mem_we;
   fb_addr_t     mem_waddr;
   fb_word_t     mem_wdata;

   //////////////////////////////////////////////////////////////////////
   // slot decode
   //////////////////////////////////////////////////////////////////////

   assign phase   = lane_t'(hcount);
   assign rd_slot = (phase == RD_PHASE) && !blank_raw;
   assign wr_slot = (phase == WR_PHASE);

   // clear owns the write slots that fall in blanking
   assign clr_write = (clr_state == CLR_RUN) && wr_slot && blank_raw;
   assign wr_ready  = wr_slot && !clr_write;

   assign mem_we    = clr_write || (wr_valid && wr_ready);
   assign mem_waddr = clr_write ? clr_addr : wr_addr;
   assign mem_wdata = clr_write ? '0 : wr_word;

   // word holding the pixel at the current raster position
   assign rd_addr = fb_addr_t'((int'(vcount) * H_ACTIVE + int'(hcount)) / PIX_PER_WORD);

   //////////////////////////////////////////////////////////////////////
   // frame memory with one access per cycle
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (mem_we) begin
         mem[mem_waddr[ADDR_W-1:0]] <= mem_wdata;
      end
   end

   // registered read so the word shows up one cycle after the slot
   always_ff @(posedge clk) begin
      if (rd_slot) begin
         rd_word <= mem[rd_addr[ADDR_W-1:0]];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // clear sequencer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         clr_state <= CLR_IDLE;
         clr_addr  <= '0;
      end else begin
         case (clr_state)
            CLR_IDLE: begin
               clr_addr <= '0;
               if (clear) begin
                  clr_state <= CLR_RUN;
               end
            end
            CLR_RUN: begin
               if (clr_write) begin
                  clr_addr <= clr_addr + 1'b1;
                  if (clr_addr == LAST_ADDR) begin
                     clr_state <= CLR_DONE;
                  end
               end
            end
            // wait for the request to drop so a held clear runs once
            CLR_DONE: begin
               if (!clear) begin
                  clr_state <= CLR_IDLE;
               end
            end
            default: clr_state <= CLR_IDLE;
         endcase
      end
   end

   assign clear_busy = (clr_state == CLR_RUN);

   // packer and clear writes both stay inside the frame
   a_waddr_range: assert property (@(posedge clk) disable iff (!rst_n)
      mem_we |-> (mem_waddr <= LAST_ADDR));

endmodule

// File: luma_packer.sv
`timescale 1ns/1ps

module luma_packer #(
   parameter int H_ACTIVE = vfb_timing_pkg::DEF_H_ACTIVE,
   parameter int V_ACTIVE = vfb_timing_pkg::DEF_V_ACTIVE
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    pix_valid,
   input  logic                    pix_sof,
   input  vfb_pixel_pkg::luma_t    pix_luma,
   output logic                    pix_ready,
   input  logic                    clear_busy,
   output logic                    wr_valid,
   output vfb_pixel_pkg::fb_addr_t wr_addr,
   output vfb_pixel_pkg::fb_word_t wr_word,
   input  logic                    wr_ready
);
   import vfb_pixel_pkg::*;

   localparam int       FRAME_WORDS = H_ACTIVE * V_ACTIVE / PIX_PER_WORD;
   localparam fb_addr_t LAST_ADDR   = fb_addr_t'(FRAME_WORDS - 1);
   localparam lane_t    LAST_LANE   = lane_t'(PIX_PER_WORD - 1);

   logic                     ready_en;
   lane_t                    lane;
   fb_addr_t                 word_addr;
   logic [WORD_W-LUMA_W-1:0] shift_q;
   logic                     accept;
   logic                     push;
   logic                     pop;
   lane_t                    cur_lane;
   fb_addr_t                 cur_addr;
   luma_t                    bin_pix;
   fb_word_t                 q_word [2];
   fb_addr_t                 q_addr [2];
   logic                     wr_ptr;
   logic                     rd_ptr;
   logic [1:0]               q_count;

   // ready_en holds input ready off for the reset cycle itself
   assign pix_ready = ready_en && (q_count != 2'd2) && !clear_busy;
   assign accept    = pix_valid && pix_ready;

   // start of frame restarts at word 0, lane 0
   assign cur_lane = pix_sof ? '0 : lane;
   assign cur_addr = pix_sof ? '0 : word_addr;

   // threshold to black or white
   assign bin_pix = (pix_luma > LUMA_THRESHOLD) ? LUMA_WHITE : LUMA_BLACK;

   // last lane completes the word
   assign push = accept && (cur_lane == LAST_LANE);
   assign pop  = wr_valid && wr_ready;

   //////////////////////////////////////////////////////////////////////
   // lane and address tracking
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ready_en  <= 1'b0;
         lane      <= '0;
         word_addr <= '0;
      end else begin
         ready_en <= 1'b1;
         if (push) begin
            lane      <= '0;
            word_addr <= (cur_addr == LAST_ADDR) ? '0 : cur_addr + 1'b1;
         end else if (accept) begin
            lane      <= cur_lane + 1'b1;
            word_addr <= cur_addr;
         end
      end
   end

   // new pixels enter at the top, so lane 0 ends up in the low byte
   always_ff @(posedge clk) begin
      if (accept) begin
         shift_q <= {bin_pix, shift_q[WORD_W-LUMA_W-1:LUMA_W]};
      end
   end

   //////////////////////////////////////////////////////////////////////
   // two-word queue towards the write port
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr  <= 1'b0;
         rd_ptr  <= 1'b0;
         q_count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= !wr_ptr;
         end
         if (pop) begin
            rd_ptr <= !rd_ptr;
         end
         if (push && !pop) begin
            q_count <= q_count + 1'b1;
         end else if (pop && !push) begin
            q_count <= q_count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         q_word[wr_ptr] <= {bin_pix, shift_q};
         q_addr[wr_ptr] <= cur_addr;
      end
   end

   assign wr_valid = (q_count != '0);
   assign wr_addr  = q_addr[rd_ptr];
   assign wr_word  = q_word[rd_ptr];

   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      push |-> (q_count != 2'd2) || pop);

   // a waiting word must not change under the arbiter
   a_word_stable: assert property (@(posedge clk) disable iff (!rst_n)
      wr_valid && !wr_ready |=> wr_valid && $stable(wr_word) && $stable(wr_addr));

endmodule

// File: vga_timing_gen.sv
`timescale 1ns/1ps

module vga_timing_gen #(
   parameter int H_ACTIVE     = vfb_timing_pkg::DEF_H_ACTIVE,
   parameter int H_SYNC_START = vfb_timing_pkg::DEF_H_SYNC_START,
   parameter int H_SYNC_END   = vfb_timing_pkg::DEF_H_SYNC_END,
   parameter int H_TOTAL      = vfb_timing_pkg::DEF_H_TOTAL,
   parameter int V_ACTIVE     = vfb_timing_pkg::DEF_V_ACTIVE,
   parameter int V_SYNC_START = vfb_timing_pkg::DEF_V_SYNC_START,
   parameter int V_SYNC_END   = vfb_timing_pkg::DEF_V_SYNC_END,
   parameter int V_TOTAL      = vfb_timing_pkg::DEF_V_TOTAL
) (
   input  logic                    clk,
   input  logic                    rst_n,
   output vfb_timing_pkg::hcount_t hcount,
   output vfb_timing_pkg::vcount_t vcount,
   output logic                    hsync_raw,
   output logic                    vsync_raw,
   output logic                    blank_raw
);
   import vfb_timing_pkg::*;

   localparam hcount_t H_LAST = hcount_t'(H_TOTAL - 1);
   localparam vcount_t V_LAST = vcount_t'(V_TOTAL - 1);

   logic h_wrap;

   assign h_wrap = (hcount == H_LAST);

   //////////////////////////////////////////////////////////////////////
   // raster counters
   //////////////////////////////////////////////////////////////////////

   // hcount runs every cycle, vcount steps once per line
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hcount <= '0;
         vcount <= '0;
      end else begin
         hcount <= h_wrap ? '0 : hcount + 1'b1;
         if (h_wrap) begin
            vcount <= (vcount == V_LAST) ? '0 : vcount + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // sync and blank decode
   //////////////////////////////////////////////////////////////////////

   // syncs are active low
   assign hsync_raw = !((hcount >= hcount_t'(H_SYNC_START)) &&
                        (hcount <  hcount_t'(H_SYNC_END)));
   assign vsync_raw = !((vcount >= vcount_t'(V_SYNC_START)) &&
                        (vcount <  vcount_t'(V_SYNC_END)));

   // blank covers both the right border and the bottom lines
   assign blank_raw = (hcount >= hcount_t'(H_ACTIVE)) ||
                      (vcount >= vcount_t'(V_ACTIVE));

   a_hcount_range: assert property (@(posedge clk) disable iff (!rst_n)
      hcount < hcount_t'(H_TOTAL));

endmodule

// File: vfb_pixel_pkg.sv
package vfb_pixel_pkg;

   // one monochrome pixel
   localparam int LUMA_W = 8;
   typedef logic [LUMA_W-1:0] luma_t;

   // packing of pixels into one memory word
   localparam int PIX_PER_WORD = 4;
   localparam int WORD_W       = LUMA_W * PIX_PER_WORD;
   typedef logic [WORD_W-1:0] fb_word_t;
   typedef logic [$clog2(PIX_PER_WORD)-1:0] lane_t;

   // word address, only the low bits a raster needs are used
   typedef logic [15:0] fb_addr_t;

   // inputs above this go white, the rest go black
   localparam int    LUMA_THRESHOLD = 127;
   localparam luma_t LUMA_WHITE     = 8'hff;
   localparam luma_t LUMA_BLACK     = 8'h00;

   // memory clear sequencer
   typedef enum logic [1:0] {
      CLR_IDLE,
      CLR_RUN,
      CLR_DONE
   } clear_state_t;

endpackage

// File: vfb_timing_pkg.sv
package vfb_timing_pkg;

   // horizontal raster position, wide enough for big rasters
   typedef logic [10:0] hcount_t;

   // vertical raster position
   typedef logic [9:0] vcount_t;

   //////////////////////////////////////////////////////////////////////
   // default raster, scaled down for simulation
   //////////////////////////////////////////////////////////////////////

   // horizontal values in pixels
   localparam int DEF_H_ACTIVE     = 32;
   localparam int DEF_H_SYNC_START = 34;
   localparam int DEF_H_SYNC_END   = 37;
   localparam int DEF_H_TOTAL      = 40;

   // vertical values in lines
   // vsync starts right at the end of the active area
   localparam int DEF_V_ACTIVE     = 8;
   localparam int DEF_V_SYNC_START = 8;
   localparam int DEF_V_SYNC_END   = 9;
   localparam int DEF_V_TOTAL      = 10;

endpackage
